// ==== sim.f ====
logic/fp_cmp_pkg.sv
logic/fp_operand_if.sv
logic/fp_special_case_detection.sv
logic/fp_classify.sv
logic/fp_compare_core.sv
logic/fp_cmp_unit.sv
bench/fp_cmp_asserts.sv
bench/fp_cmp_tb.sv

// ==== Makefile ====
TOP := fp_cmp_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f sim.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir

// ==== bench/fp_cmp_tb.sv ====
`timescale 1ns/1ps

module fp_cmp_tb;

  import fp_cmp_pkg::*;

  localparam int NUM_REQ     = 4000;
  localparam int DRAIN_LIMIT = 20;
  localparam logic [31:0] QNAN_CANON = 32'h7fc0_0000;

  typedef struct packed {
    fp_op_t      op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    logic        invalid;
    int unsigned due;  // Cycle count at which the response is seen.
  } expect_t;

  logic        clk;
  logic        arst_n;
  logic        in_valid;
  fp_op_t      op;
  logic [31:0] a;
  logic [31:0] b;
  logic        out_valid;
  logic [31:0] result;
  logic        invalid;

  expect_t     pending[$];
  int unsigned cycle = 0;
  int          errors = 0;
  int          checked = 0;

  fp_cmp_unit i_fp_cmp_unit (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .op       (op),
    .a        (a),
    .b        (b),
    .out_valid(out_valid),
    .result   (result),
    .invalid  (invalid)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic nan_of(input logic [31:0] w);
    return (&w[30:23]) && (w[22:0] != 23'h0);
  endfunction

  function automatic logic snan_of(input logic [31:0] w);
    return nan_of(w) && !w[22];  // Quiet bit clear.
  endfunction

  // Signed key in numeric order where both zeros map to 0.
  function automatic logic signed [32:0] key_of(input logic [31:0] w);
    logic signed [32:0] mag;
    mag = {2'b00, w[30:0]};
    return w[31] ? -mag : mag;
  endfunction

  function automatic logic [9:0] class_of(input logic [31:0] w);
    logic [9:0] m;
    m = '0;
    if (nan_of(w)) m[w[22] ? 9 : 8] = 1'b1;
    else if (&w[30:23]) m[w[31] ? 0 : 7] = 1'b1;
    else if (w[30:0] == 31'h0) m[w[31] ? 3 : 4] = 1'b1;
    else if (w[30:23] == 8'h00) m[w[31] ? 2 : 5] = 1'b1;
    else m[w[31] ? 1 : 6] = 1'b1;
    return m;
  endfunction

  function automatic void model(input fp_op_t o, input logic [31:0] x, input logic [31:0] y,
                                output logic [31:0] res, output logic inv);
    logic               na;
    logic               nb;
    logic               any_snan;
    logic signed [32:0] kx;
    logic signed [32:0] ky;
    logic [31:0]        lo;
    logic [31:0]        hi;
    na       = nan_of(x);
    nb       = nan_of(y);
    any_snan = snan_of(x) | snan_of(y);
    kx       = key_of(x);
    ky       = key_of(y);
    if (na && nb) begin
      lo = QNAN_CANON;
      hi = QNAN_CANON;
    end else if (na || nb) begin
      lo = na ? y : x;  // The number is returned.
      hi = lo;
    end else if (kx < ky || (kx == ky && x[31] && !y[31])) begin
      lo = x;  // Also -0 against +0.
      hi = y;
    end else if (ky < kx || (kx == ky && y[31] && !x[31])) begin
      lo = y;
      hi = x;
    end else begin
      lo = x;
      hi = x;
    end
    res = '0;
    inv = 1'b0;
    case (o)
      FEQ: begin
        res[0] = !na && !nb && kx == ky;
        inv    = any_snan;
      end
      FLT: begin
        res[0] = !na && !nb && kx < ky;
        inv    = na | nb;
      end
      FLE: begin
        res[0] = !na && !nb && kx <= ky;
        inv    = na | nb;
      end
      FMIN: begin
        res = lo;
        inv = any_snan;
      end
      FMAX: begin
        res = hi;
        inv = any_snan;
      end
      default: res[9:0] = class_of(x);
    endcase
  endfunction

  function automatic logic [31:0] subnormal_word();
    return {1'($urandom_range(0, 1)), 8'h00, 23'($urandom) | 23'h1};
  endfunction

  function automatic logic [31:0] special_word();
    logic        sgn;
    logic [22:0] f;
    sgn = 1'($urandom_range(0, 1));
    f   = 23'($urandom);
    case ($urandom_range(0, 5))
      0: return {sgn, 8'h00, 23'h0};
      1: return {sgn, 8'hff, 23'h0};
      2: return {sgn, 8'hff, 1'b1, f[21:0]};
      3: return {sgn, 8'hff, 1'b0, f[21:1], 1'b1};  // Payload kept nonzero.
      4: return subnormal_word();
      default: return {sgn, 8'($urandom_range(1, 254)), f};
    endcase
  endfunction

  task automatic check_output();
    expect_t e;
    fp_op_t  eop;
    if (out_valid) begin
      if (pending.size() == 0) begin
        $display("Unexpected out_valid pulse with no request pending, cycle %0d", cycle);
        errors++;
      end else begin
        e   = pending.pop_front();
        eop = e.op;
        checked++;
        if (cycle != e.due) begin
          $display("Response for %s arrived at cycle %0d, due at %0d", eop.name(), cycle, e.due);
          errors++;
        end
        if (result !== e.result) begin
          $display("** Error: result = %h, expected %h (%s a=%h b=%h)",
                   result, e.result, eop.name(), e.a, e.b);
          errors++;
        end
        if (invalid !== e.invalid) begin
          $display("** Error: invalid = %h, expected %h (%s a=%h b=%h)",
                   invalid, e.invalid, eop.name(), e.a, e.b);
          errors++;
        end
      end
    end else if (pending.size() != 0 && pending[0].due <= cycle) begin
      $display("Missing out_valid pulse for a request due at cycle %0d", pending[0].due);
      errors++;
      void'(pending.pop_front());
    end
  endtask

  task automatic drive_request();
    expect_t     e;
    logic [31:0] res;
    logic        inv;
    int unsigned mode;
    mode = $urandom_range(0, 99);
    if (mode < 30) begin
      a = $urandom;
      b = $urandom;
    end else if (mode < 60) begin
      a = special_word();
      b = special_word();
    end else if (mode < 75) begin
      a = special_word();
      b = a;
    end else if (mode < 88) begin
      a = special_word();
      b = a ^ 32'h8000_0000;  // Sign flip only.
    end else begin
      a = subnormal_word();
      b = ($urandom_range(0, 1) != 0) ? subnormal_word() : special_word();
    end
    op       = fp_op_t'(3'($urandom_range(0, 5)));
    in_valid = ($urandom_range(0, 99) < 70);
    if (in_valid) begin
      model(op, a, b, res, inv);
      e.op      = op;
      e.a       = a;
      e.b       = b;
      e.result  = res;
      e.invalid = inv;
      e.due     = cycle + 2;  // Captured at the next edge and registered once more.
      pending.push_back(e);
    end
  endtask

  initial begin
    int wait_cnt;
    void'($urandom(32'hef4b));
    arst_n   = 1'b0;
    in_valid = 1'b0;
    op       = FEQ;
    a        = '0;
    b        = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    if (out_valid !== 1'b0 || result !== 32'h0 || invalid !== 1'b0) begin
      $display("** Error: reset out_valid = %h result = %h invalid = %h, expected 0",
               out_valid, result, invalid);
      errors++;
    end
    arst_n = 1'b1;
    for (int i = 0; i < NUM_REQ; i++) begin
      @(negedge clk);
      check_output();
      drive_request();
    end
    wait_cnt = 0;
    while (pending.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
      @(negedge clk);
      check_output();
      in_valid = 1'b0;
      wait_cnt++;
    end
    if (pending.size() != 0) begin
      $display("Timed out waiting for %0d outstanding responses", pending.size());
      errors++;
    end
    repeat (4) begin
      @(negedge clk);
      check_output();  // No stray pulses once idle.
    end
    $display("Checked %0d responses, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/fp_cmp_asserts.sv ====
`timescale 1ns/1ps

module fp_cmp_asserts #(
  parameter int FRAC_W = 23,
  parameter int EXPO_W = 8,
  localparam int WIDTH = FRAC_W + EXPO_W + 1
) (
  input logic               clk,
  input logic               arst_n,
  input logic               in_valid,
  input fp_cmp_pkg::fp_op_t op,
  input logic               out_valid,
  input logic [WIDTH-1:0]   result,
  input logic               invalid
);

  import fp_cmp_pkg::*;

  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == $past(in_valid, 2))
    else $error("out_valid does not follow in_valid by two cycles");

  // Compare opcodes return a single bit.
  a_cmp_bit: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && ($past(op, 2) inside {FEQ, FLT, FLE}) |-> result[WIDTH-1:1] == '0)
    else $error("compare result wider than one bit");

  a_class_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && $past(op, 2) == FCLASS |->
      $onehot(result[FCLASS_W-1:0]) && result[WIDTH-1:FCLASS_W] == '0 && !invalid)
    else $error("class mask not one-hot or invalid set");

endmodule

bind fp_cmp_unit fp_cmp_asserts #(
  .FRAC_W(FRAC_W),
  .EXPO_W(EXPO_W)
) i_fp_cmp_asserts (
  .clk      (clk),
  .arst_n   (arst_n),
  .in_valid (in_valid),
  .op       (op),
  .out_valid(out_valid),
  .result   (result),
  .invalid  (invalid)
);

// ==== logic/fp_cmp_unit.sv ====
`timescale 1ns/1ps

module fp_cmp_unit #(
  parameter int FRAC_W           = 23,
  parameter int EXPO_W           = 8,
  parameter bit ENABLE_SUBNORMAL = 1'b1,
  localparam int WIDTH           = FRAC_W + EXPO_W + 1
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               in_valid,
  input  fp_cmp_pkg::fp_op_t op,
  input  logic [WIDTH-1:0]   a,
  input  logic [WIDTH-1:0]   b,
  output logic               out_valid,
  output logic [WIDTH-1:0]   result,
  output logic               invalid
);

  import fp_cmp_pkg::*;

  logic   valid_q;  // Stage 1 register in step with the operand registers.
  fp_op_t op_q;

  fp_operand_if #(.FRAC_W(FRAC_W), .EXPO_W(EXPO_W)) op_a ();
  fp_operand_if #(.FRAC_W(FRAC_W), .EXPO_W(EXPO_W)) op_b ();

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      op_q    <= FEQ;
    end else begin
      valid_q <= in_valid;
      op_q    <= op;
    end
  end

  fp_special_case_detection #(
    .FRAC_W          (FRAC_W),
    .EXPO_W          (EXPO_W),
    .ENABLE_SUBNORMAL(ENABLE_SUBNORMAL)
  ) i_detect_a (
    .clk   (clk),
    .arst_n(arst_n),
    .data  (a),
    .opnd  (op_a)
  );

  fp_special_case_detection #(
    .FRAC_W          (FRAC_W),
    .EXPO_W          (EXPO_W),
    .ENABLE_SUBNORMAL(ENABLE_SUBNORMAL)
  ) i_detect_b (
    .clk   (clk),
    .arst_n(arst_n),
    .data  (b),
    .opnd  (op_b)
  );

  // Stage 2 result and flag.
  fp_compare_core #(
    .FRAC_W          (FRAC_W),
    .EXPO_W          (EXPO_W),
    .ENABLE_SUBNORMAL(ENABLE_SUBNORMAL)
  ) i_fp_compare_core (
    .clk      (clk),
    .arst_n   (arst_n),
    .valid    (valid_q),
    .op       (op_q),
    .opnd_a   (op_a),
    .opnd_b   (op_b),
    .out_valid(out_valid),
    .result   (result),
    .invalid  (invalid)
  );

endmodule

// ==== logic/fp_compare_core.sv ====
`timescale 1ns/1ps

module fp_compare_core #(
  parameter int FRAC_W           = 23,
  parameter int EXPO_W           = 8,
  parameter bit ENABLE_SUBNORMAL = 1'b1,
  localparam int WIDTH           = FRAC_W + EXPO_W + 1
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              valid,
  input  fp_cmp_pkg::fp_op_t op,
  fp_operand_if.dst         opnd_a,
  fp_operand_if.dst         opnd_b,
  output logic              out_valid,
  output logic [WIDTH-1:0]  result,
  output logic              invalid
);

  import fp_cmp_pkg::*;

  // Sign 0, exponent all ones, only the quiet bit set.
  localparam logic [WIDTH-1:0] CANON_NAN = {1'b0, {EXPO_W{1'b1}}, 1'b1, {(FRAC_W-1){1'b0}}};

  logic [EXPO_W+FRAC_W-1:0] mag_a;
  logic [EXPO_W+FRAC_W-1:0] mag_b;
  logic [FCLASS_W-1:0]      class_mask;
  logic                     nan_a;
  logic                     nan_b;
  logic                     any_snan;
  logic                     both_zero;
  logic                     eq;
  logic                     lt;
  logic                     mm_lt;  // Min/max ordering puts -0 below +0.
  logic                     mm_gt;
  logic [WIDTH-1:0]         min_val;
  logic [WIDTH-1:0]         max_val;
  logic [WIDTH-1:0]         result_d;
  logic                     invalid_d;

  fp_classify #(
    .ENABLE_SUBNORMAL(ENABLE_SUBNORMAL)
  ) i_fp_classify (
    .opnd(opnd_a),
    .mask(class_mask)
  );

  assign nan_a    = opnd_a.is_snan | opnd_a.is_qnan;
  assign nan_b    = opnd_b.is_snan | opnd_b.is_qnan;
  assign any_snan = opnd_a.is_snan | opnd_b.is_snan;

  // Flushed operands count as magnitude zero.
  assign mag_a     = opnd_a.is_zero ? '0 : {opnd_a.expo, opnd_a.frac};
  assign mag_b     = opnd_b.is_zero ? '0 : {opnd_b.expo, opnd_b.frac};
  assign both_zero = opnd_a.is_zero & opnd_b.is_zero;

  assign eq = both_zero | ((opnd_a.sign == opnd_b.sign) & (mag_a == mag_b));

  always_comb begin
    if (both_zero) begin
      lt = 1'b0;
    end else if (opnd_a.sign != opnd_b.sign) begin
      lt = opnd_a.sign;  // Negative side is smaller.
    end else if (opnd_a.sign) begin
      lt = mag_a > mag_b;
    end else begin
      lt = mag_a < mag_b;
    end
  end

  assign mm_lt = both_zero ? (opnd_a.sign & ~opnd_b.sign) : lt;
  assign mm_gt = both_zero ? (~opnd_a.sign & opnd_b.sign) : (~lt & ~eq);

  always_comb begin
    if (nan_a & nan_b) begin
      min_val = CANON_NAN;
      max_val = CANON_NAN;
    end else if (nan_a) begin
      min_val = opnd_b.word;  // The number wins over a NaN.
      max_val = opnd_b.word;
    end else if (nan_b) begin
      min_val = opnd_a.word;
      max_val = opnd_a.word;
    end else begin
      min_val = mm_gt ? opnd_b.word : opnd_a.word;
      max_val = mm_lt ? opnd_b.word : opnd_a.word;
    end
  end

  always_comb begin
    result_d  = '0;
    invalid_d = 1'b0;
    case (op)
      FEQ: begin
        result_d[0] = eq & ~nan_a & ~nan_b;
        invalid_d   = any_snan;  // Quiet compare.
      end
      FLT: begin
        result_d[0] = lt & ~nan_a & ~nan_b;
        invalid_d   = nan_a | nan_b;
      end
      FLE: begin
        result_d[0] = (lt | eq) & ~nan_a & ~nan_b;
        invalid_d   = nan_a | nan_b;
      end
      FMIN: begin
        result_d  = min_val;
        invalid_d = any_snan;
      end
      FMAX: begin
        result_d  = max_val;
        invalid_d = any_snan;
      end
      FCLASS: result_d[FCLASS_W-1:0] = class_mask;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
      invalid   <= 1'b0;
    end else begin
      out_valid <= valid;
      result    <= result_d;
      invalid   <= invalid_d;
    end
  end

endmodule

// ==== logic/fp_classify.sv ====
`timescale 1ns/1ps

module fp_classify #(
  parameter bit ENABLE_SUBNORMAL = 1'b1
) (
  fp_operand_if.dst                    opnd,
  output logic [fp_cmp_pkg::FCLASS_W-1:0] mask
);

  import fp_cmp_pkg::*;

  logic is_nan;
  logic is_sub;
  logic is_norm;
  logic neg;
  logic pos;

  assign is_nan = opnd.is_snan | opnd.is_qnan;

  // Nonzero operand with a zero exponent and no leading one.
  assign is_sub = ENABLE_SUBNORMAL & ~|opnd.expo & ~opnd.hidden & ~opnd.is_zero;

  assign is_norm = ~(opnd.is_inf | is_nan | opnd.is_zero | is_sub);
  assign neg     = opnd.sign & ~is_nan;  // NaN classes ignore the sign.
  assign pos     = ~opnd.sign & ~is_nan;

  always_comb begin
    mask               = '0;
    mask[CLS_NEG_INF]  = neg & opnd.is_inf;
    mask[CLS_NEG_NORM] = neg & is_norm;
    mask[CLS_NEG_SUB]  = neg & is_sub;
    mask[CLS_NEG_ZERO] = neg & opnd.is_zero;
    mask[CLS_POS_ZERO] = pos & opnd.is_zero;
    mask[CLS_POS_SUB]  = pos & is_sub;
    mask[CLS_POS_NORM] = pos & is_norm;
    mask[CLS_POS_INF]  = pos & opnd.is_inf;
    mask[CLS_SNAN]     = opnd.is_snan;
    mask[CLS_QNAN]     = opnd.is_qnan;
  end

endmodule

// ==== logic/fp_special_case_detection.sv ====
`timescale 1ns/1ps

module fp_special_case_detection #(
  parameter int FRAC_W           = 23,
  parameter int EXPO_W           = 8,
  parameter bit ENABLE_SUBNORMAL = 1'b1,
  localparam int WIDTH           = FRAC_W + EXPO_W + 1
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [WIDTH-1:0] data,
  fp_operand_if.src        opnd
);

  logic              sign_in;
  logic [EXPO_W-1:0] expo_in;
  logic [FRAC_W-1:0] frac_in;
  logic              expo_ones;
  logic              expo_zero;
  logic              frac_zero;
  logic              zero_in;
  logic              hidden_in;

  assign {sign_in, expo_in, frac_in} = data;  // Unpack.
  assign expo_ones = &expo_in;
  assign expo_zero = ~|expo_in;
  assign frac_zero = ~|frac_in;

  if (ENABLE_SUBNORMAL) begin : g_subnormal
    assign zero_in   = expo_zero & frac_zero;
    assign hidden_in = ~expo_zero;  // Subnormals have no leading one.
  end else begin : g_flush
    // Any zero exponent reads as zero when flushing
    assign zero_in   = expo_zero;
    assign hidden_in = 1'b1;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      opnd.is_inf  <= 1'b0;
      opnd.is_snan <= 1'b0;
      opnd.is_qnan <= 1'b0;
      opnd.is_zero <= 1'b0;
      opnd.hidden  <= 1'b0;
    end else begin
      opnd.is_inf  <= expo_ones & frac_zero;
      opnd.is_snan <= expo_ones & ~frac_zero & ~frac_in[FRAC_W-1];  // Quiet bit clear.
      opnd.is_qnan <= expo_ones & frac_in[FRAC_W-1];
      opnd.is_zero <= zero_in;
      opnd.hidden  <= hidden_in;
    end
  end

  always_ff @(posedge clk) begin
    opnd.word <= data;
    opnd.sign <= sign_in;
    opnd.expo <= expo_in;
    opnd.frac <= frac_in;
  end

endmodule

// ==== logic/fp_operand_if.sv ====
`timescale 1ns/1ps

interface fp_operand_if #(
  parameter int FRAC_W = 23,
  parameter int EXPO_W = 8,
  localparam int WIDTH = FRAC_W + EXPO_W + 1
);

  logic [WIDTH-1:0]  word;     // Raw operand bits.
  logic              sign;
  logic [EXPO_W-1:0] expo;
  logic [FRAC_W-1:0] frac;
  logic              hidden;   // Implicit leading bit.
  logic              is_inf;
  logic              is_snan;
  logic              is_qnan;
  logic              is_zero;  // Includes flushed subnormals.

  modport src (
    output word, sign, expo, frac, hidden,
    output is_inf, is_snan, is_qnan, is_zero
  );

  modport dst (
    input word, sign, expo, frac, hidden,
    input is_inf, is_snan, is_qnan, is_zero
  );

endinterface

// ==== logic/fp_cmp_pkg.sv ====
package fp_cmp_pkg;

  // Opcodes of the compare and classify unit.
  typedef enum logic [2:0] {
    FEQ    = 3'd0,  // a == b.
    FLT    = 3'd1,  // a < b.
    FLE    = 3'd2,  // a <= b.
    FMIN   = 3'd3,  // Smaller operand.
    FMAX   = 3'd4,  // Larger operand.
    FCLASS = 3'd5   // Class mask of a.
  } fp_op_t;

  // Width of the RISC-V class mask.
  localparam int FCLASS_W = 10;

  // Bit positions inside the class mask
  localparam int CLS_NEG_INF  = 0;
  localparam int CLS_NEG_NORM = 1;
  localparam int CLS_NEG_SUB  = 2;
  localparam int CLS_NEG_ZERO = 3;
  localparam int CLS_POS_ZERO = 4;
  localparam int CLS_POS_SUB  = 5;
  localparam int CLS_POS_NORM = 6;
  localparam int CLS_POS_INF  = 7;
  localparam int CLS_SNAN     = 8;
  localparam int CLS_QNAN     = 9;

endpackage
